// ==== kitchen_timer.f ====
+incdir+.
timer_types_pkg.sv
display_pkg.sv
tick_divider.sv
bcd_time_counter.sv
time_compare.sv
timer_control.sv
seg_display.sv
kitchen_timer.sv
kitchen_timer_checker.sv
kitchen_timer_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= kitchen_timer_tb
FILELIST   ?= kitchen_timer.f
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== kitchen_timer_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "timer_consts.svh"

module kitchen_timer_tb;

  import timer_types_pkg::*;
  import display_pkg::*;

  localparam int tick_div = 4;

  typedef enum int {
    op_none, op_load_time, op_load_alarm, op_start_up, op_start_down,
    op_pause, op_clear, op_run, op_rand_up, op_rand_down
  } op_t;

  typedef struct {
    op_t       op;
    time_bcd_t value;
    int        n;
    time_bcd_t exp_time;
    logic      exp_running;
    logic      exp_alarm;
  } row_t;

  logic      clk;
  logic      reset_n;
  logic      start;
  logic      pause;
  logic      clear;
  logic      load_time;
  logic      load_alarm;
  logic      count_up;
  time_bcd_t set_value;
  segment_t  hex3;
  segment_t  hex2;
  segment_t  hex1;
  segment_t  hex0;
  logic      running;
  logic      alarm;

  logic      check;
  time_bcd_t exp_time;
  logic      exp_running;
  logic      exp_alarm;
  int        pass_count;
  int        fail_count;

  row_t        rows[$];
  logic [31:0] rng;
  logic        timed_out;

  kitchen_timer #(
    .tick_div (tick_div)
  ) dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .pause      (pause),
    .clear      (clear),
    .load_time  (load_time),
    .load_alarm (load_alarm),
    .count_up   (count_up),
    .set_value  (set_value),
    .hex3       (hex3),
    .hex2       (hex2),
    .hex1       (hex1),
    .hex0       (hex0),
    .running    (running),
    .alarm      (alarm)
  );

  kitchen_timer_checker chk (
    .clk         (clk),
    .reset_n     (reset_n),
    .check       (check),
    .exp_time    (exp_time),
    .exp_running (exp_running),
    .exp_alarm   (exp_alarm),
    .hex3        (hex3),
    .hex2        (hex2),
    .hex1        (hex1),
    .hex0        (hex0),
    .running     (running),
    .alarm       (alarm),
    .pass_count  (pass_count),
    .fail_count  (fail_count)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // counting down keeps a minute ones digit of at least 1 so the run cannot end,
  // counting up keeps the minute tens below 9 so it stays clear of 99:59
  function automatic time_bcd_t random_time(input logic [31:0] r, input logic down);
    time_bcd_t t;
    t.min_tens = down ? bcd_digit_t'(int'(r[3:0]) % 10) : bcd_digit_t'(int'(r[3:0]) % 9);
    t.min_ones = down ? bcd_digit_t'(int'(r[11:8]) % 9 + 1) : bcd_digit_t'(int'(r[11:8]) % 10);
    t.sec_tens = bcd_digit_t'(int'(r[19:16]) % 6);
    t.sec_ones = bcd_digit_t'(int'(r[27:24]) % 10);
    return t;
  endfunction

  // reference model works in plain seconds and clamps to the display range
  function automatic time_bcd_t add_seconds(input time_bcd_t t, input int n, input logic up);
    int        secs;
    time_bcd_t r;
    secs = t.min_tens * 600 + t.min_ones * 60 + t.sec_tens * 10 + t.sec_ones;
    secs = up ? secs + n : secs - n;
    if (secs > 99 * 60 + 59) secs = 99 * 60 + 59;
    if (secs < 0) secs = 0;
    r.min_tens = bcd_digit_t'(secs / 600);
    r.min_ones = bcd_digit_t'((secs / 60) % 10);
    r.sec_tens = bcd_digit_t'((secs % 60) / 10);
    r.sec_ones = bcd_digit_t'(secs % 10);
    return r;
  endfunction

  task automatic add_row(input op_t op, input logic [15:0] value, input int n,
                         input logic [15:0] t, input logic run, input logic alm);
    row_t r;
    r.op          = op;
    r.value       = time_bcd_t'(value);
    r.n           = n;
    r.exp_time    = time_bcd_t'(t);
    r.exp_running = run;
    r.exp_alarm   = alm;
    rows.push_back(r);
  endtask

  // called 2 ns after an edge, returns 2 ns after the edge that took the pulse
  task automatic pulse_op(input op_t op, input time_bcd_t value);
    set_value = value;
    case (op)
      op_load_time:  load_time = 1'b1;
      op_load_alarm: load_alarm = 1'b1;
      op_start_up: begin
        start    = 1'b1;
        count_up = 1'b1;
      end
      op_start_down: begin
        start    = 1'b1;
        count_up = 1'b0;
      end
      op_pause: pause = 1'b1;
      op_clear: clear = 1'b1;
      default: ;
    endcase
    @(posedge clk);
    #2;
    start      = 1'b0;
    pause      = 1'b0;
    clear      = 1'b0;
    load_time  = 1'b0;
    load_alarm = 1'b0;
  endtask

  // a tick seen in a cycle moves the counter on the following edge
  task automatic run_ticks(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n && cycles < n * tick_div * 2 + 8) begin
      if (dut.tick) seen++;
      @(posedge clk);
      #2;
      cycles++;
    end
    if (seen < n) begin
      timed_out = 1'b1;
      $display("Timeout: saw only %0d of %0d ticks at %0t", seen, n, $time);
    end
  endtask

  task automatic request_check(input time_bcd_t t, input logic run, input logic alm);
    @(posedge clk);
    #2;
    exp_time    = t;
    exp_running = run;
    exp_alarm   = alm;
    check       = 1'b1;
    @(posedge clk);
    #2;
    check = 1'b0;
  endtask

  initial begin
    int        fails_before;
    row_t      r;
    time_bcd_t value;
    logic      up;
    clk         = 1'b0;
    reset_n     = 1'b0;
    start       = 1'b0;
    pause       = 1'b0;
    clear       = 1'b0;
    load_time   = 1'b0;
    load_alarm  = 1'b0;
    count_up    = 1'b0;
    set_value   = '0;
    check       = 1'b0;
    exp_time    = '0;
    exp_running = 1'b0;
    exp_alarm   = 1'b0;
    rng         = 32'had3fa985;
    timed_out   = 1'b0;

    add_row(op_none,       16'h0000, 0, 16'h0000, 0, 0);
    add_row(op_load_alarm, 16'h9959, 0, 16'h0000, 0, 0);
    add_row(op_load_time,  16'h0158, 0, 16'h0158, 0, 0);
    add_row(op_start_up,   16'h0000, 0, 16'h0158, 1, 0);
    add_row(op_run,        16'h0000, 3, 16'h0201, 1, 0);
    add_row(op_clear,      16'h0000, 0, 16'h0000, 0, 0);
    add_row(op_load_time,  16'h0003, 0, 16'h0003, 0, 0);
    add_row(op_start_down, 16'h0000, 0, 16'h0003, 1, 0);
    add_row(op_run,        16'h0000, 3, 16'h0000, 0, 1);
    add_row(op_run,        16'h0000, 2, 16'h0000, 0, 1);
    add_row(op_load_alarm, 16'h0005, 0, 16'h0000, 0, 0);
    add_row(op_load_time,  16'h0002, 0, 16'h0002, 0, 0);
    add_row(op_start_up,   16'h0000, 0, 16'h0002, 1, 0);
    add_row(op_run,        16'h0000, 3, 16'h0005, 0, 1);
    add_row(op_load_time,  16'h0130, 0, 16'h0130, 0, 0);
    add_row(op_load_alarm, 16'h9959, 0, 16'h0130, 0, 0);
    add_row(op_start_down, 16'h0000, 0, 16'h0130, 1, 0);
    add_row(op_run,        16'h0000, 2, 16'h0128, 1, 0);
    add_row(op_pause,      16'h0000, 0, 16'h0128, 0, 0);
    add_row(op_run,        16'h0000, 3, 16'h0128, 0, 0);
    add_row(op_start_down, 16'h0000, 0, 16'h0128, 1, 0);
    add_row(op_run,        16'h0000, 2, 16'h0126, 1, 0);
    add_row(op_clear,      16'h0000, 0, 16'h0000, 0, 0);
    add_row(op_load_time,  16'h9958, 0, 16'h9958, 0, 0);
    add_row(op_start_up,   16'h0000, 0, 16'h9958, 1, 0);
    add_row(op_run,        16'h0000, 2, 16'h9959, 0, 1);
    add_row(op_load_time,  16'h0001, 0, 16'h0001, 0, 0);
    add_row(op_start_down, 16'h0000, 0, 16'h0001, 1, 0);
    add_row(op_run,        16'h0000, 3, 16'h0000, 0, 1);
    add_row(op_clear,      16'h0000, 0, 16'h0000, 0, 0);
    add_row(op_rand_down,  16'h0000, 3, 16'h0000, 1, 0);
    add_row(op_clear,      16'h0000, 0, 16'h0000, 0, 0);
    add_row(op_rand_up,    16'h0000, 3, 16'h0000, 1, 0);

    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      r            = rows[i];
      fails_before = fail_count;
      if (r.op == op_run) begin
        run_ticks(r.n);
      end else if (r.op == op_rand_up || r.op == op_rand_down) begin
        up         = (r.op == op_rand_up);
        rng        = xorshift(rng);
        value      = random_time(rng, !up);
        r.exp_time = add_seconds(value, r.n, up);
        pulse_op(op_load_time, value);
        pulse_op(up ? op_start_up : op_start_down, '0);
        run_ticks(r.n);
      end else begin
        pulse_op(r.op, r.value);
      end
      if (timed_out) break;
      request_check(r.exp_time, r.exp_running, r.exp_alarm);
      $display("row %0d %s: %s", i, r.op.name(), (fail_count == fails_before) ? "ok" : "error");
    end

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : kitchen_timer_tb

`default_nettype wire

// ==== kitchen_timer_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "timer_consts.svh"

module kitchen_timer_checker (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       check,
  input  timer_types_pkg::time_bcd_t exp_time,
  input  logic                       exp_running,
  input  logic                       exp_alarm,
  input  display_pkg::segment_t      hex3,
  input  display_pkg::segment_t      hex2,
  input  display_pkg::segment_t      hex1,
  input  display_pkg::segment_t      hex0,
  input  logic                       running,
  input  logic                       alarm,
  output int                         pass_count,
  output int                         fail_count
);

  import timer_types_pkg::*;
  import display_pkg::*;

  // turns an active-low pattern back into a digit, top bit says it was legal
  function automatic logic [4:0] seg_to_digit(input segment_t seg);
    logic [4:0] res;
    case (seg)
      7'b100_0000: res = 5'h10;
      7'b111_1001: res = 5'h11;
      7'b010_0100: res = 5'h12;
      7'b011_0000: res = 5'h13;
      7'b001_1001: res = 5'h14;
      7'b001_0010: res = 5'h15;
      7'b000_0010: res = 5'h16;
      7'b111_1000: res = 5'h17;
      7'b000_0000: res = 5'h18;
      7'b001_0000: res = 5'h19;
      default:     res = 5'h00;
    endcase
    return res;
  endfunction

  always @(posedge clk or negedge reset_n) begin : compare_blk
    display_t                     shown;
    bcd_digit_t [`NUM_DIGITS-1:0] want;
    logic [4:0]                   dec;
    logic                         ok;
    if (!reset_n) begin
      pass_count <= 0;
      fail_count <= 0;
    end else if (check) begin
      shown = {hex3, hex2, hex1, hex0};
      want  = exp_time;
      ok    = 1'b1;
      for (int i = 0; i < `NUM_DIGITS; i++) begin
        // a zero in the minute tens has to be dark, not a drawn zero
        if (i == `NUM_DIGITS - 1 && want[i] == '0) begin
          if (shown[i] != `SEG_BLANK) begin
            ok = 1'b0;
            $display("CHECK FAILED at %0t: digit %0d should be blank, segments %b",
                     $time, i, shown[i]);
          end
        end else begin
          dec = seg_to_digit(shown[i]);
          if (!dec[4] || dec[3:0] != want[i]) begin
            ok = 1'b0;
            $display("CHECK FAILED at %0t: digit %0d expected %0d, segments %b",
                     $time, i, want[i], shown[i]);
          end
        end
      end
      if (running != exp_running) begin
        ok = 1'b0;
        $display("CHECK FAILED at %0t: running is %b, expected %b",
                 $time, running, exp_running);
      end
      if (alarm != exp_alarm) begin
        ok = 1'b0;
        $display("CHECK FAILED at %0t: alarm is %b, expected %b", $time, alarm, exp_alarm);
      end
      if (ok) begin
        pass_count <= pass_count + 1;
      end else begin
        fail_count <= fail_count + 1;
      end
    end
  end

endmodule : kitchen_timer_checker

`default_nettype wire

// ==== kitchen_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "timer_consts.svh"

module kitchen_timer #(
  parameter int tick_div = `TICK_DIV_DEFAULT
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       start,
  input  logic                       pause,
  input  logic                       clear,
  input  logic                       load_time,
  input  logic                       load_alarm,
  input  logic                       count_up,
  input  timer_types_pkg::time_bcd_t set_value,
  output display_pkg::segment_t      hex3,
  output display_pkg::segment_t      hex2,
  output display_pkg::segment_t      hex1,
  output display_pkg::segment_t      hex0,
  output logic                       running,
  output logic                       alarm
);

  import timer_types_pkg::*;

  logic      tick_restart;
  logic      tick;
  logic      count_en;
  logic      count_dir;
  logic      counter_load;
  logic      counter_clear;
  logic      step;
  logic      at_end;
  time_bcd_t time_now;
  time_bcd_t setpoint;

  // the counter only moves on ticks while the FSM is running
  assign step = tick && count_en;

  timer_control u_control (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .pause         (pause),
    .clear         (clear),
    .load_time     (load_time),
    .load_alarm    (load_alarm),
    .count_up      (count_up),
    .set_value     (set_value),
    .tick          (tick),
    .at_end        (at_end),
    .tick_restart  (tick_restart),
    .count_en      (count_en),
    .count_dir     (count_dir),
    .counter_load  (counter_load),
    .counter_clear (counter_clear),
    .setpoint      (setpoint),
    .running       (running),
    .alarm         (alarm)
  );

  tick_divider #(
    .tick_div (tick_div)
  ) u_divider (
    .clk     (clk),
    .reset_n (reset_n),
    .restart (tick_restart),
    .tick    (tick)
  );

  bcd_time_counter u_counter (
    .clk        (clk),
    .reset_n    (reset_n),
    .step       (step),
    .up         (count_dir),
    .load       (counter_load),
    .clear      (counter_clear),
    .load_value (set_value),
    .time_now   (time_now)
  );

  time_compare u_compare (
    .time_now (time_now),
    .setpoint (setpoint),
    .up       (count_dir),
    .at_end   (at_end)
  );

  seg_display u_display (
    .time_now (time_now),
    .hex3     (hex3),
    .hex2     (hex2),
    .hex1     (hex1),
    .hex0     (hex0)
  );

endmodule : kitchen_timer

`default_nettype wire

// ==== seg_display.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "timer_consts.svh"

module seg_display (
  input  timer_types_pkg::time_bcd_t time_now,
  output display_pkg::segment_t      hex3,
  output display_pkg::segment_t      hex2,
  output display_pkg::segment_t      hex1,
  output display_pkg::segment_t      hex0
);

  import timer_types_pkg::*;
  import display_pkg::*;

  bcd_digit_t [`NUM_DIGITS-1:0] digits;
  display_t                     segs;

  // full hex table, so a bad digit still shows something readable
  function automatic segment_t decode(input bcd_digit_t bcd);
    segment_t seg;
    case (bcd)
      4'h0: seg = 7'b100_0000;
      4'h1: seg = 7'b111_1001;
      4'h2: seg = 7'b010_0100;
      4'h3: seg = 7'b011_0000;
      4'h4: seg = 7'b001_1001;
      4'h5: seg = 7'b001_0010;
      4'h6: seg = 7'b000_0010;
      4'h7: seg = 7'b111_1000;
      4'h8: seg = 7'b000_0000;
      4'h9: seg = 7'b001_0000;
      4'ha: seg = 7'b000_1000;
      4'hb: seg = 7'b000_0011;
      4'hc: seg = 7'b100_0110;
      4'hd: seg = 7'b010_0001;
      4'he: seg = 7'b000_0110;
      default: seg = 7'b000_1110;
    endcase
    return seg;
  endfunction

  // digit 3 is minute tens, digit 0 is second ones
  assign digits = time_now;

  always_comb begin
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      segs[i] = decode(digits[i]);
    end
    // a leading zero on the minutes is not shown
    if (digits[`NUM_DIGITS-1] == '0) begin
      segs[`NUM_DIGITS-1] = `SEG_BLANK;
    end
  end

  assign hex3 = segs[3];
  assign hex2 = segs[2];
  assign hex1 = segs[1];
  assign hex0 = segs[0];

endmodule : seg_display

`default_nettype wire

// ==== timer_control.sv ====
`default_nettype none
`timescale 1ns/100ps

module timer_control (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       start,
  input  logic                       pause,
  input  logic                       clear,
  input  logic                       load_time,
  input  logic                       load_alarm,
  input  logic                       count_up,
  input  timer_types_pkg::time_bcd_t set_value,
  input  logic                       tick,
  input  logic                       at_end,
  output logic                       tick_restart,
  output logic                       count_en,
  output logic                       count_dir,
  output logic                       counter_load,
  output logic                       counter_clear,
  output timer_types_pkg::time_bcd_t setpoint,
  output logic                       running,
  output logic                       alarm
);

  import timer_types_pkg::*;

  timer_state_t state;
  timer_state_t state_next;
  logic         dir_q;
  logic         start_ok;
  logic         take_load;

  // start is honoured only from idle or paused, and clear overrides it
  assign start_ok = start && !clear && (state == st_idle || state == st_paused);

  // loads are ignored while running
  assign take_load = !clear && !start_ok && (state != st_running);

  // during the start cycle the comparator already sees the new direction,
  // so a start that is already at its end point can expire at once
  assign count_dir = start_ok ? count_up : dir_q;

  assign tick_restart  = start_ok;
  assign counter_clear = clear;
  assign counter_load  = load_time && take_load;

  // a tick landing in the cycle the end is seen must not step past it
  assign count_en = (state == st_running) && !(tick && at_end);

  assign running = (state == st_running);
  assign alarm   = (state == st_expired);

  always_comb begin
    state_next = state;
    if (clear) begin
      state_next = st_idle;
    end else begin
      case (state)
        st_idle, st_paused: begin
          if (start_ok) begin
            state_next = at_end ? st_expired : st_running;
          end else if (load_time || load_alarm) begin
            state_next = st_idle;
          end
        end
        st_running: begin
          if (at_end) begin
            state_next = st_expired;
          end else if (pause) begin
            state_next = st_paused;
          end
        end
        st_expired: begin
          // alarm holds here until a clear or a new load
          if (load_time || load_alarm) begin
            state_next = st_idle;
          end
        end
        default: state_next = st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= st_idle;
      dir_q    <= 1'b0;
      setpoint <= '0;
    end else begin
      state <= state_next;
      if (start_ok) begin
        dir_q <= count_up;
      end
      if (load_alarm && take_load) begin
        setpoint <= set_value;
      end
    end
  end

endmodule : timer_control

`default_nettype wire

// ==== time_compare.sv ====
`default_nettype none
`timescale 1ns/100ps

module time_compare (
  input  timer_types_pkg::time_bcd_t time_now,
  input  timer_types_pkg::time_bcd_t setpoint,
  input  logic                       up,
  output logic                       at_end
);

  // packed BCD with the most significant digit on top orders the
  // same way as an unsigned binary number
  logic [$bits(time_now)-1:0] now_val;
  logic [$bits(setpoint)-1:0] set_val;
  logic now_zero;
  logic now_ge_set;

  assign now_val = time_now;
  assign set_val = setpoint;

  assign now_zero   = (now_val == '0);
  assign now_ge_set = (now_val >= set_val);

  // counting down ends at 00:00, counting up ends at the setpoint
  assign at_end = up ? now_ge_set : now_zero;

endmodule : time_compare

`default_nettype wire

// ==== bcd_time_counter.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "timer_consts.svh"

module bcd_time_counter (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     step,
  input  logic                     up,
  input  logic                     load,
  input  logic                     clear,
  input  timer_types_pkg::time_bcd_t load_value,
  output timer_types_pkg::time_bcd_t time_now
);

  import timer_types_pkg::*;

  // the count saturates here when counting up
  localparam time_bcd_t time_max = '{`DIGIT_MAX, `DIGIT_MAX, `SEC_TENS_MAX, `DIGIT_MAX};

  time_bcd_t next_up;
  time_bcd_t next_down;

  // one second forward, carrying digit by digit
  always_comb begin
    next_up = time_now;
    if (time_now != time_max) begin
      if (time_now.sec_ones != `DIGIT_MAX) begin
        next_up.sec_ones = time_now.sec_ones + 4'd1;
      end else begin
        next_up.sec_ones = '0;
        if (time_now.sec_tens != `SEC_TENS_MAX) begin
          next_up.sec_tens = time_now.sec_tens + 4'd1;
        end else begin
          next_up.sec_tens = '0;
          if (time_now.min_ones != `DIGIT_MAX) begin
            next_up.min_ones = time_now.min_ones + 4'd1;
          end else begin
            // min_tens is below 9 here since 99:59 was excluded above
            next_up.min_ones = '0;
            next_up.min_tens = time_now.min_tens + 4'd1;
          end
        end
      end
    end
  end

  // one second back, borrowing digit by digit
  always_comb begin
    next_down = time_now;
    if (time_now != '0) begin
      if (time_now.sec_ones != '0) begin
        next_down.sec_ones = time_now.sec_ones - 4'd1;
      end else begin
        next_down.sec_ones = `DIGIT_MAX;
        if (time_now.sec_tens != '0) begin
          next_down.sec_tens = time_now.sec_tens - 4'd1;
        end else begin
          next_down.sec_tens = `SEC_TENS_MAX;
          if (time_now.min_ones != '0) begin
            next_down.min_ones = time_now.min_ones - 4'd1;
          end else begin
            next_down.min_ones = `DIGIT_MAX;
            next_down.min_tens = time_now.min_tens - 4'd1;
          end
        end
      end
    end
  end

  // clear beats load, load beats a step
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      time_now <= '0;
    end else if (clear) begin
      time_now <= '0;
    end else if (load) begin
      time_now <= load_value;
    end else if (step) begin
      time_now <= up ? next_up : next_down;
    end
  end

endmodule : bcd_time_counter

`default_nettype wire

// ==== tick_divider.sv ====
`default_nettype none
`timescale 1ns/100ps

module tick_divider #(
  parameter int tick_div = 2
) (
  input  logic clk,
  input  logic reset_n,
  input  logic restart,
  output logic tick
);

  // one extra bit so that tick_div itself always fits
  localparam int count_w = $clog2(tick_div + 1);
  localparam logic [count_w-1:0] count_reload = count_w'(tick_div - 1);

  logic [count_w-1:0] count;

  assign tick = (count == '0);

  // restart reloads the full interval, so the first tick after it
  // lands exactly tick_div cycles later
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count <= count_reload;
    end else if (restart) begin
      count <= count_reload;
    end else if (count == '0) begin
      count <= count_reload;
    end else begin
      count <= count - 1'b1;
    end
  end

endmodule : tick_divider

`default_nettype wire

// ==== display_pkg.sv ====
`default_nettype none

`include "timer_consts.svh"

package display_pkg;

  // seven active-low segments, bit 0 is segment a and bit 6 is segment g
  typedef logic [6:0] segment_t;

  // the whole display, index 0 is the rightmost digit
  typedef segment_t [`NUM_DIGITS-1:0] display_t;

endpackage : display_pkg

`default_nettype wire

// ==== timer_types_pkg.sv ====
`default_nettype none

package timer_types_pkg;

  // one decimal digit
  typedef logic [3:0] bcd_digit_t;

  // mm:ss packed with minute tens in the top nibble, so that two
  // legal values compare correctly as plain unsigned numbers
  typedef struct packed {
    bcd_digit_t min_tens;
    bcd_digit_t min_ones;
    bcd_digit_t sec_tens;
    bcd_digit_t sec_ones;
  } time_bcd_t;

  // control state of the timer
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_running = 2'd1,
    st_paused  = 2'd2,
    st_expired = 2'd3
  } timer_state_t;

endpackage : timer_types_pkg

`default_nettype wire

// ==== timer_consts.svh ====
`ifndef TIMER_CONSTS_SVH
`define TIMER_CONSTS_SVH

// clock cycles per one-second tick on a 50 MHz board clock
`define TICK_DIV_DEFAULT 50_000_000

// largest value of a decimal digit and of the seconds-tens digit
`define DIGIT_MAX 4'd9
`define SEC_TENS_MAX 4'd5

// number of seven-segment digits on the display
`define NUM_DIGITS 4

// segments are active low, so all ones turns the digit off
`define SEG_BLANK 7'b111_1111

`endif
